// File: wh_top.f
+incdir+include
source/wh_pkg.sv
source/wh_buffer.sv
source/wh_weight_bank.sv
source/wh_mac_array.sv
source/wh_ctrl.sv
source/wh_top.sv
tb/wh_assertions.sv
tb/wh_checker.sv
tb/wh_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the wh_top testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module wh_tb -f wh_top.f -o wh_sim \
  && ./obj_dir/wh_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// File: tb/wh_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wh_config.svh"

module wh_tb;

  localparam int H_N            = `WH_NODES * `WH_FEAT_IN;
  localparam int W_N            = `WH_FEAT_IN * `WH_FEAT_OUT;
  localparam int R_N            = `WH_NODES * `WH_FEAT_OUT;
  localparam int ROUNDS         = 3;
  // Longest access, strobe held four edges past the ack
  localparam int ACCESS_CYCLES  = 7;
  // Loads, readbacks, results, then polls and extras
  localparam int ROUND_ACCESSES = 2 * (H_N + W_N) + R_N + 40;
  localparam int TIMEOUT_CYCLES =
    ROUNDS * (ROUND_ACCESSES * ACCESS_CYCLES + H_N + 3) + 16 + 500;

  logic                 clk;
  logic                 arst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [`WH_ADR_W-1:0] wb_adr;
  logic [`WH_BUS_W-1:0] wb_dat_w;
  wire  [`WH_BUS_W-1:0] wb_dat_r;
  wire                  wb_ack;
  wire                  done;
  int                   errors;
  int                   cycles;

  wh_top uut (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .done     (done)
  );

  wh_checker u_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .done     (done),
    .errors   (errors)
  );

  bind wh_ctrl wh_assertions u_assertions (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .busy   (busy),
    .done   (done)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic bus_access(
    input  logic                 we,
    input  logic [`WH_ADR_W-1:0] adr,
    input  logic [`WH_BUS_W-1:0] wdat,
    output logic [`WH_BUS_W-1:0] rdat
  );
    int hold;
    hold = 1 + $urandom_range(3);
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_ack);
    rdat = wb_dat_r;
    // Strobe stays up for one to four edges after the ack
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [`WH_ADR_W-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input logic [`WH_ADR_W-1:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  // Element in the low byte, junk above it
  function automatic logic [31:0] make_word(input int round);
    logic [7:0] elem;
    int         pick;
    pick = $urandom_range(3);
    if (round == 2) begin
      elem = 8'h80;
    end else if (round == 1 && pick == 0) begin
      elem = 8'h80;
    end else if (round == 1 && pick == 1) begin
      elem = 8'h7f;
    end else begin
      elem = 8'($urandom());
    end
    return {24'($urandom()), elem};
  endfunction

  task automatic run_round(input int round);
    logic [31:0]          rd;
    logic [`WH_ADR_W-1:0] late_adr [$];
    for (int i = 0; i < H_N; i++) begin
      bus_write(10'(`WH_H_BASE + i), make_word(round));
    end
    for (int i = 0; i < W_N; i++) begin
      bus_write(10'(`WH_W_BASE + i), make_word(round));
    end
    for (int i = 0; i < (round == 0 ? H_N : 8); i++) begin
      bus_read(10'(`WH_H_BASE + (round == 0 ? i : $urandom_range(H_N - 1))), rd);
    end
    for (int i = 0; i < (round == 0 ? W_N : 8); i++) begin
      bus_read(10'(`WH_W_BASE + (round == 0 ? i : $urandom_range(W_N - 1))), rd);
    end
    bus_write(`WH_CTRL_ADR, {31'($urandom()), 1'b1});
    bus_read(`WH_STATUS_ADR, rd);
    // Writes during the run must be dropped
    for (int i = 0; i < 2; i++) begin
      late_adr.push_back(10'(`WH_H_BASE + $urandom_range(H_N - 1)));
      bus_write(late_adr[$], make_word(0));
      late_adr.push_back(10'(`WH_W_BASE + $urandom_range(W_N - 1)));
      bus_write(late_adr[$], make_word(0));
    end
    bus_write(`WH_CTRL_ADR, 32'h1);
    do begin
      bus_read(`WH_STATUS_ADR, rd);
    end while (!rd[1]);
    for (int i = 0; i < R_N; i++) begin
      bus_read(10'(`WH_R_BASE + i), rd);
    end
    foreach (late_adr[i]) begin
      bus_read(late_adr[i], rd);
    end
    bus_read(`WH_CTRL_ADR, rd);
    bus_read(10'(10'h002 + $urandom_range(253)), rd);
    bus_read(10'(10'h140 + $urandom_range(191)), rd);
    bus_read(10'(10'h220 + $urandom_range(223)), rd);
    bus_read(10'(10'h320 + $urandom_range(223)), rd);
  endtask

  initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    cycles   = 0;
    void'($urandom(32'ha24a));
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    for (int r = 0; r < ROUNDS; r++) begin
      run_round(r);
    end
    repeat (4) @(posedge clk);
    $display("checker errors: %0d, assertion failures: %0d",
             errors, uut.u_ctrl.u_assertions.fails);
    if (errors == 0 && uut.u_ctrl.u_assertions.fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/wh_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "wh_config.svh"

module wh_checker
  import wh_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 wb_cyc,
  input  wire logic                 wb_stb,
  input  wire logic                 wb_we,
  input  wire logic [`WH_ADR_W-1:0] wb_adr,
  input  wire logic [`WH_BUS_W-1:0] wb_dat_w,
  input  wire logic [`WH_BUS_W-1:0] wb_dat_r,
  input  wire logic                 wb_ack,
  input  wire logic                 done,
  output int                        errors
);

  localparam int NODES = `WH_NODES;
  localparam int FI    = `WH_FEAT_IN;
  localparam int FO    = `WH_FEAT_OUT;
  localparam int H_N   = NODES * FI;
  localparam int W_N   = FI * FO;
  localparam int R_N   = NODES * FO;

  int         h_m [H_N];
  int         w_m [W_N];
  int         wh_m [R_N];
  int         run_left;
  int         edges;
  logic       busy_m;
  logic       busy_pre;
  logic       done_m;
  logic       results_ok;
  logic       in_access;
  logic       acked;
  logic [2:0] busy_hist;
  logic [1:0] stat_d1;
  logic [1:0] stat_d2;

  // WH[n][k] is the sum over j of H[n][j] * W[j][k]
  task automatic compute_wh();
    for (int n = 0; n < NODES; n++) begin
      for (int k = 0; k < FO; k++) begin
        wh_m[n * FO + k] = 0;
        for (int j = 0; j < FI; j++) begin
          wh_m[n * FO + k] += h_m[n * FI + j] * w_m[j * FO + k];
        end
      end
    end
  endtask

  task automatic apply_write(input logic [`WH_ADR_W-1:0] adr, input logic [31:0] dat);
    logic [`WH_ADR_W-1:0] h_off;
    logic [`WH_ADR_W-1:0] w_off;
    h_off = adr - `WH_H_BASE;
    w_off = adr - `WH_W_BASE;
    if (!busy_m) begin
      if (h_off < H_N) begin
        h_m[int'(h_off)] = int'(h_elem_t'(dat[7:0]));
      end else if (w_off < W_N) begin
        w_m[int'(w_off)] = int'(w_elem_t'(dat[7:0]));
      end else if (adr == `WH_CTRL_ADR && dat[0]) begin
        busy_m   = 1'b1;
        done_m   = 1'b0;
        run_left = H_N + 3;
      end
    end
  endtask

  task automatic check_read(input logic [`WH_ADR_W-1:0] adr, input logic [31:0] got);
    logic [`WH_ADR_W-1:0] h_off;
    logic [`WH_ADR_W-1:0] w_off;
    logic [`WH_ADR_W-1:0] r_off;
    logic [31:0]          exp;
    logic                 known;
    h_off = adr - `WH_H_BASE;
    w_off = adr - `WH_W_BASE;
    r_off = adr - `WH_R_BASE;
    exp   = '0;
    known = 1'b1;
    // Status is captured two edges before the ack
    if (adr == `WH_STATUS_ADR) begin
      exp = {30'b0, stat_d2};
    end else if (h_off < H_N) begin
      exp   = h_m[int'(h_off)];
      known = busy_hist == '0;
    end else if (w_off < W_N) begin
      exp = w_m[int'(w_off)];
    end else if (r_off < R_N) begin
      exp   = wh_m[int'(r_off)];
      known = results_ok && busy_hist == '0;
    end
    if (known && got !== exp) begin
      errors++;
      $display("MISMATCH wb_dat_r adr=%03h exp=%08h got=%08h", adr, exp, got);
    end
  endtask

  always @(posedge clk) begin
    if (!arst_n) begin
      errors     = 0;
      busy_m     = 1'b0;
      done_m     = 1'b0;
      results_ok = 1'b0;
      in_access  = 1'b0;
      acked      = 1'b0;
      edges      = 0;
      run_left   = 0;
      busy_hist  = '0;
      stat_d1    = '0;
      stat_d2    = '0;
      // Weight bank clears on reset
      for (int i = 0; i < W_N; i++) begin
        w_m[i] = 0;
      end
    end else begin
      busy_pre = busy_m;
      if (done !== done_m) begin
        errors++;
        $display("MISMATCH done exp=%h got=%h", done_m, done);
      end
      if (wb_cyc && wb_stb) begin
        if (!in_access) begin
          in_access = 1'b1;
          acked     = 1'b0;
          edges     = 0;
        end
        edges++;
        if (wb_ack) begin
          if (acked) begin
            errors++;
            $display("access at address %03h was acknowledged twice", wb_adr);
          end else if (edges != 3) begin
            errors++;
            $display("access at address %03h was acknowledged on the wrong cycle", wb_adr);
          end
          acked = 1'b1;
          if (wb_we) begin
            apply_write(wb_adr, wb_dat_w);
          end else begin
            check_read(wb_adr, wb_dat_r);
          end
        end else if (!acked && edges == 3) begin
          errors++;
          $display("access at address %03h was not acknowledged in time", wb_adr);
        end
      end else begin
        in_access = 1'b0;
      end
      // Run length is fixed by the sequencer
      if (busy_pre) begin
        run_left--;
        if (run_left == 0) begin
          busy_m     = 1'b0;
          done_m     = 1'b1;
          results_ok = 1'b1;
          compute_wh();
        end
      end
      busy_hist = {busy_hist[1:0], busy_m};
      stat_d2   = stat_d1;
      stat_d1   = {done_m, busy_m};
    end
  end

endmodule

`default_nettype wire

// File: tb/wh_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module wh_assertions (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic wb_cyc,
  input wire logic wb_stb,
  input wire logic wb_ack,
  input wire logic busy,
  input wire logic done
);

  int fails = 0;

  // Ack only answers an active request
  ack_in_cycle: assert property (
    @(posedge clk) disable iff (!arst_n) wb_ack |-> wb_cyc && wb_stb
  ) else begin
    $error("wb_ack high without wb_cyc and wb_stb");
    fails++;
  end

  single_ack: assert property (
    @(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack
  ) else begin
    $error("wb_ack high for two cycles in a row");
    fails++;
  end

  busy_done_excl: assert property (
    @(posedge clk) disable iff (!arst_n) !(busy && done)
  ) else begin
    $error("busy and done high together");
    fails++;
  end

endmodule

`default_nettype wire

// File: source/wh_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wh_config.svh"

module wh_top
  import wh_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 wb_cyc,
  input  wire logic                 wb_stb,
  input  wire logic                 wb_we,
  input  wire logic [`WH_ADR_W-1:0] wb_adr,
  input  wire logic [`WH_BUS_W-1:0] wb_dat_w,
  output wire logic [`WH_BUS_W-1:0] wb_dat_r,
  output wire logic                 wb_ack,
  output wire logic                 done
);

  logic                h_we;
  logic [`WH_H_AW-1:0] h_waddr;
  h_elem_t             h_wdata;
  logic [`WH_H_AW-1:0] h_raddr;
  h_elem_t             h_rdata;

  logic                w_we;
  logic [`WH_W_AW-1:0] w_addr;
  w_elem_t             w_wdata;
  w_elem_t             w_rdata;
  logic [`WH_F_AW-1:0] w_row_sel;
  w_row_t              w_row;

  logic                mac_valid;
  logic                mac_first;
  logic                mac_last;
  logic                row_valid;
  wh_row_t             mac_row;

  logic                r_we;
  logic [`WH_N_AW-1:0] r_waddr;
  logic [`WH_N_AW-1:0] r_raddr;
  wh_row_t             r_rdata;

  wh_ctrl u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .h_rdata   (h_rdata),
    .w_rdata   (w_rdata),
    .r_rdata   (r_rdata),
    .row_valid (row_valid),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .done      (done),
    .h_we      (h_we),
    .h_waddr   (h_waddr),
    .h_wdata   (h_wdata),
    .h_raddr   (h_raddr),
    .w_we      (w_we),
    .w_addr    (w_addr),
    .w_wdata   (w_wdata),
    .w_row_sel (w_row_sel),
    .mac_valid (mac_valid),
    .mac_first (mac_first),
    .mac_last  (mac_last),
    .r_we      (r_we),
    .r_waddr   (r_waddr),
    .r_raddr   (r_raddr)
  );

  // Dense H, one element per word
  wh_buffer #(
    .T     (h_elem_t),
    .DEPTH (`WH_NODES * `WH_FEAT_IN)
  ) u_h_buf (
    .clk   (clk),
    .we    (h_we),
    .waddr (h_waddr),
    .wdata (h_wdata),
    .raddr (h_raddr),
    .rdata (h_rdata)
  );

  // One packed WH row per node
  wh_buffer #(
    .T     (wh_row_t),
    .DEPTH (`WH_NODES)
  ) u_r_buf (
    .clk   (clk),
    .we    (r_we),
    .waddr (r_waddr),
    .wdata (mac_row),
    .raddr (r_raddr),
    .rdata (r_rdata)
  );

  wh_weight_bank u_w_bank (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (w_we),
    .addr    (w_addr),
    .wdata   (w_wdata),
    .row_sel (w_row_sel),
    .rdata   (w_rdata),
    .row     (w_row)
  );

  wh_mac_array u_mac (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (mac_valid),
    .first     (mac_first),
    .last      (mac_last),
    .h_in      (h_rdata),
    .w_in      (w_row),
    .row_valid (row_valid),
    .row       (mac_row)
  );

endmodule

`default_nettype wire

// File: source/wh_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "wh_config.svh"

module wh_ctrl
  import wh_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 wb_cyc,
  input  wire logic                 wb_stb,
  input  wire logic                 wb_we,
  input  wire logic [`WH_ADR_W-1:0] wb_adr,
  input  wire logic [`WH_BUS_W-1:0] wb_dat_w,
  input  wire h_elem_t              h_rdata,
  input  wire w_elem_t              w_rdata,
  input  wire wh_row_t              r_rdata,
  input  wire logic                 row_valid,
  output logic [`WH_BUS_W-1:0]      wb_dat_r,
  output logic                      wb_ack,
  output logic                      done,
  output logic                      h_we,
  output logic [`WH_H_AW-1:0]       h_waddr,
  output h_elem_t                   h_wdata,
  output logic [`WH_H_AW-1:0]       h_raddr,
  output logic                      w_we,
  output logic [`WH_W_AW-1:0]       w_addr,
  output w_elem_t                   w_wdata,
  output logic [`WH_F_AW-1:0]       w_row_sel,
  output logic                      mac_valid,
  output logic                      mac_first,
  output logic                      mac_last,
  output logic                      r_we,
  output logic [`WH_N_AW-1:0]       r_waddr,
  output logic [`WH_N_AW-1:0]       r_raddr
);

  localparam int NODES   = `WH_NODES;
  localparam int FI      = `WH_FEAT_IN;
  localparam int FO      = `WH_FEAT_OUT;
  localparam int BW      = `WH_BUS_W;
  localparam int DW      = `WH_DATA_W;
  localparam int AW      = `WH_ADR_W;
  localparam int H_AW    = `WH_H_AW;
  localparam int W_AW    = `WH_W_AW;
  localparam int N_AW    = `WH_N_AW;
  localparam int F_AW    = `WH_F_AW;
  localparam int K_AW    = `WH_K_AW;
  localparam int H_DEPTH = NODES * FI;
  localparam int W_DEPTH = FI * FO;
  localparam int R_DEPTH = NODES * FO;

  logic            bus_req;
  logic            req_q;
  logic            hold_q;
  logic            wr_stb;
  logic            start;
  logic            ctrl_sel;
  logic            status_sel;
  logic            h_sel;
  logic            w_sel;
  logic            r_sel;
  logic [AW-1:0]   h_off;
  logic [AW-1:0]   w_off;
  logic [AW-1:0]   r_off;
  logic [K_AW-1:0] r_lane;
  logic [BW-1:0]   rd_data;
  logic [H_AW-1:0] seq_addr;
  logic            busy;
  logic            issue;
  logic [N_AW-1:0] node_cnt;
  logic [F_AW-1:0] feat_cnt;
  logic [N_AW-1:0] row_cnt;

  // Address decode
  assign bus_req    = wb_cyc && wb_stb;
  assign ctrl_sel   = wb_adr == `WH_CTRL_ADR;
  assign status_sel = wb_adr == `WH_STATUS_ADR;
  assign h_off      = wb_adr - `WH_H_BASE;
  assign w_off      = wb_adr - `WH_W_BASE;
  assign r_off      = wb_adr - `WH_R_BASE;
  assign h_sel      = h_off < H_DEPTH;
  assign w_sel      = w_off < W_DEPTH;
  assign r_sel      = r_off < R_DEPTH;
  assign r_lane     = K_AW'(r_off % FO);
  assign r_raddr    = N_AW'(r_off / FO);

  // Two-phase ack, then wait for stb to drop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_q  <= 1'b0;
      wb_ack <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      req_q  <= bus_req && !req_q && !wb_ack && !hold_q;
      wb_ack <= bus_req && req_q;
      hold_q <= bus_req && (wb_ack || hold_q);
    end
  end

  always_comb begin
    rd_data = '0;
    if (status_sel) begin
      rd_data = {{(BW-2){1'b0}}, done, busy};
    end else if (h_sel) begin
      rd_data = BW'(h_rdata);
    end else if (w_sel) begin
      rd_data = BW'(w_rdata);
    end else if (r_sel) begin
      rd_data = BW'(r_rdata[r_lane]);
    end
  end

  // Buffer data has settled by the second phase
  always_ff @(posedge clk) begin
    if (req_q) begin
      wb_dat_r <= rd_data;
    end
  end

  // Writes land in the ack cycle, dropped while busy
  assign wr_stb  = wb_ack && bus_req && wb_we && !busy;
  assign start   = wr_stb && ctrl_sel && wb_dat_w[0];
  assign h_we    = wr_stb && h_sel;
  assign h_waddr = H_AW'(h_off);
  assign h_wdata = h_elem_t'(wb_dat_w[DW-1:0]);
  assign w_we    = wr_stb && w_sel;
  assign w_addr  = W_AW'(w_off);
  assign w_wdata = w_elem_t'(wb_dat_w[DW-1:0]);

  assign seq_addr = H_AW'(node_cnt * FI) + H_AW'(feat_cnt);
  assign h_raddr  = busy ? seq_addr : H_AW'(h_off);

  // Run sequencer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      issue    <= 1'b0;
      node_cnt <= '0;
      feat_cnt <= '0;
      row_cnt  <= '0;
    end else if (start) begin
      busy     <= 1'b1;
      done     <= 1'b0;
      issue    <= 1'b1;
      node_cnt <= '0;
      feat_cnt <= '0;
      row_cnt  <= '0;
    end else begin
      if (issue) begin
        if (feat_cnt == F_AW'(FI - 1)) begin
          feat_cnt <= '0;
          node_cnt <= node_cnt + 1'b1;
          if (node_cnt == N_AW'(NODES - 1)) begin
            issue <= 1'b0;
          end
        end else begin
          feat_cnt <= feat_cnt + 1'b1;
        end
      end
      if (row_valid) begin
        row_cnt <= row_cnt + 1'b1;
        // Final row written this cycle
        if (row_cnt == N_AW'(NODES - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Flags follow the H buffer read latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mac_valid <= 1'b0;
      mac_first <= 1'b0;
      mac_last  <= 1'b0;
      w_row_sel <= '0;
    end else begin
      mac_valid <= issue;
      mac_first <= issue && feat_cnt == '0;
      mac_last  <= issue && feat_cnt == F_AW'(FI - 1);
      w_row_sel <= feat_cnt;
    end
  end

  assign r_we    = row_valid;
  assign r_waddr = row_cnt;

endmodule

`default_nettype wire

// File: source/wh_mac_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "wh_config.svh"

module wh_mac_array
  import wh_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  input  wire logic    valid,
  input  wire logic    first,
  input  wire logic    last,
  input  wire h_elem_t h_in,
  input  wire w_row_t  w_in,
  output logic         row_valid,
  output wh_row_t      row
);

  logic    prod_valid;
  logic    prod_first;
  logic    prod_last;
  wh_row_t prod_q;
  wh_row_t acc_q;
  wh_row_t sum;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_valid <= 1'b0;
      prod_first <= 1'b0;
      prod_last  <= 1'b0;
      row_valid  <= 1'b0;
    end else begin
      prod_valid <= valid;
      prod_first <= first;
      prod_last  <= last;
      row_valid  <= prod_valid && prod_last;
    end
  end

  // Product stage, sign extended to the accumulator width
  always_ff @(posedge clk) begin
    if (valid) begin
      for (int k = 0; k < `WH_FEAT_OUT; k++) begin
        prod_q[k] <= h_in * w_in[k];
      end
    end
  end

  // first reloads instead of adding
  always_comb begin
    for (int k = 0; k < `WH_FEAT_OUT; k++) begin
      sum[k] = prod_first ? prod_q[k] : acc_q[k] + prod_q[k];
    end
  end

  // Next node can start right behind the last element
  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc_q <= sum;
    end
    if (prod_valid && prod_last) begin
      row <= sum;
    end
  end

endmodule

`default_nettype wire

// File: source/wh_weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "wh_config.svh"

module wh_weight_bank
  import wh_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                we,
  input  wire logic [`WH_W_AW-1:0] addr,
  input  wire w_elem_t             wdata,
  input  wire logic [`WH_F_AW-1:0] row_sel,
  output w_elem_t                  rdata,
  output w_row_t                   row
);

  localparam int FI   = `WH_FEAT_IN;
  localparam int FO   = `WH_FEAT_OUT;
  localparam int F_AW = `WH_F_AW;
  localparam int K_AW = `WH_K_AW;

  w_row_t bank [FI];

  logic [F_AW-1:0] sel_j;
  logic [K_AW-1:0] sel_k;

  // addr = j * FEAT_OUT + k
  assign sel_j = F_AW'(addr / FO);
  assign sel_k = K_AW'(addr % FO);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int j = 0; j < FI; j++) begin
        bank[j] <= '0;
      end
    end else if (we) begin
      bank[sel_j][sel_k] <= wdata;
    end
  end

  assign rdata = bank[sel_j][sel_k];

  // Whole row for the MAC lanes
  assign row = bank[row_sel];

endmodule

`default_nettype wire

// File: source/wh_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module wh_buffer #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 64,
  localparam int AW    = $clog2(DEPTH)
) (
  input  wire logic          clk,
  input  wire logic          we,
  input  wire logic [AW-1:0] waddr,
  input  wire T              wdata,
  input  wire logic [AW-1:0] raddr,
  output T                   rdata
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: source/wh_pkg.sv
`default_nettype none

`include "wh_config.svh"

package wh_pkg;

  // One H feature element
  typedef logic signed [`WH_DATA_W-1:0] h_elem_t;

  // One weight element
  typedef logic signed [`WH_DATA_W-1:0] w_elem_t;

  // Full precision accumulation, no saturation
  typedef logic signed [`WH_ACC_W-1:0] acc_t;

  // Weights of one input feature, lane k in element k
  typedef w_elem_t [`WH_FEAT_OUT-1:0] w_row_t;

  // One WH row, output feature k in element k
  typedef acc_t [`WH_FEAT_OUT-1:0] wh_row_t;

endpackage

`default_nettype wire

// File: include/wh_config.svh
`ifndef WH_CONFIG_SVH
`define WH_CONFIG_SVH

// Problem size
`define WH_NODES    8
`define WH_FEAT_IN  8
`define WH_FEAT_OUT 4

// Element, accumulator and bus widths
`define WH_DATA_W 8
`define WH_ACC_W  19
`define WH_BUS_W  32
`define WH_ADR_W  10

// Index widths derived from the sizes
`define WH_N_AW $clog2(`WH_NODES)
`define WH_F_AW $clog2(`WH_FEAT_IN)
`define WH_K_AW $clog2(`WH_FEAT_OUT)
`define WH_H_AW $clog2(`WH_NODES * `WH_FEAT_IN)
`define WH_W_AW $clog2(`WH_FEAT_IN * `WH_FEAT_OUT)

// Word address map
`define WH_CTRL_ADR   10'h000
`define WH_STATUS_ADR 10'h001
`define WH_H_BASE     10'h100
`define WH_W_BASE     10'h200
`define WH_R_BASE     10'h300

`endif
